//--- logic/alu_pkg.sv
package alu_pkg;

    localparam int DATA_W    = 8;                   // Operand and result width
    localparam int OPCODE_W  = 8;                   // Opcode field width
    localparam int CMD_DEPTH = 4;                   // Command FIFO entries
    localparam int RES_DEPTH = 4;                   // Result FIFO entries
    localparam int ADDR_W    = 4;                   // APB address width
    localparam int APB_DW    = 32;                  // APB data width
    localparam int RD_VALID_BIT = 16;               // Valid bit in read word

    localparam logic [OPCODE_W-1:0] OP_ADD  = 8'd1;
    localparam logic [OPCODE_W-1:0] OP_SUB  = 8'd2;
    localparam logic [OPCODE_W-1:0] OP_MUL  = 8'd3;  // Low byte of product
    localparam logic [OPCODE_W-1:0] OP_AND  = 8'd6;
    localparam logic [OPCODE_W-1:0] OP_OR   = 8'd7;
    localparam logic [OPCODE_W-1:0] OP_XOR  = 8'd8;
    localparam logic [OPCODE_W-1:0] OP_NOT  = 8'd9;  // Operand1 only
    localparam logic [OPCODE_W-1:0] OP_NOR  = 8'd10;
    localparam logic [OPCODE_W-1:0] OP_NAND = 8'd11;
    localparam logic [OPCODE_W-1:0] OP_XNOR = 8'd12;

    localparam logic [ADDR_W-1:0] ADDR_CMD = 4'h0;  // Write only
    localparam logic [ADDR_W-1:0] ADDR_RES = 4'h4;  // Read only

    typedef struct packed {
        logic v;                                    // Bit 3
        logic c;
        logic s;
        logic z;                                    // Bit 0
    } alu_flags_t;

    // Same layout as pwdata[23:0]
    typedef struct packed {
        logic [OPCODE_W-1:0] opcode;                // Bits 23:16
        logic [DATA_W-1:0]   operand2;              // Bits 15:8
        logic [DATA_W-1:0]   operand1;              // Bits 7:0
    } alu_cmd_t;

    typedef struct packed {
        alu_flags_t        flags;                   // Bits 11:8
        logic [DATA_W-1:0] result;                  // Bits 7:0
    } alu_res_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

//--- logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic push,
    input  T     push_data,
    output logic full,
    input  logic pop,
    output T     pop_data,
    output logic empty
);

    T                             mem [DEPTH];      // Storage, no reset
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;            // Occupancy
    logic                         do_push;
    logic                         do_pop;

    assign full    = (count == $bits(count)'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign pop_data = mem[rd_ptr];                  // Show-ahead head

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)                            // Wrap at DEPTH
                wr_ptr <= (wr_ptr == $bits(wr_ptr)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == $bits(rd_ptr)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset) push |-> !full
    ) else $error("push while full");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset) pop |-> !empty
    ) else $error("pop while empty");

endmodule

//--- logic/apb_cmd_port.sv
`timescale 1ns/1ps

module apb_cmd_port import alu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output logic     cmd_push,
    output alu_cmd_t cmd_data,
    input  logic     cmd_full,
    output logic     res_pop,
    input  alu_res_t res_data,
    input  logic     res_empty
);

    logic              access;                      // APB access phase
    logic              cmd_sel;                     // Address hits command reg
    logic              res_sel;                     // Address hits result reg
    logic              opcode_ok;                   // Opcode in kept set
    logic              cmd_write;                   // Legal command write
    logic              read_res;                    // Legal result read
    logic              bad_access;                  // Completes with error
    logic              stall;                       // Write waits for space
    logic              pready_q;
    logic              pslverr_q;
    logic [APB_DW-1:0] rd_word;

    assign access  = apb_req.psel & apb_req.penable;
    assign cmd_sel = (apb_req.paddr == ADDR_CMD);
    assign res_sel = (apb_req.paddr == ADDR_RES);

    // Command fields sit in the low bytes of pwdata
    assign cmd_data = alu_cmd_t'(apb_req.pwdata[$bits(alu_cmd_t)-1:0]);

    // Only opcode check in the design
    always_comb begin
        case (cmd_data.opcode)
            OP_ADD, OP_SUB, OP_MUL,
            OP_AND, OP_OR, OP_XOR, OP_NOT,
            OP_NOR, OP_NAND, OP_XNOR: opcode_ok = 1'b1;
            default:                  opcode_ok = 1'b0;
        endcase
    end

    assign cmd_write  = apb_req.pwrite & cmd_sel & opcode_ok;
    assign read_res   = ~apb_req.pwrite & res_sel;
    assign bad_access = apb_req.pwrite ? ~cmd_write : ~res_sel;
    assign stall      = cmd_write & cmd_full;       // Back-pressure on full FIFO

    // Push and pop fire on the completing edge
    assign cmd_push = access & pready_q & cmd_write;
    assign res_pop  = access & pready_q & read_res & ~res_empty;

    // Ready goes high one cycle after the request can be served
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
        end else if (pready_q) begin
            pready_q  <= 1'b0;                      // Transfer ends here
            pslverr_q <= 1'b0;
        end else begin
            pready_q  <= apb_req.psel & ~stall;     // Setup or stalled access
            pslverr_q <= apb_req.psel & bad_access;
        end
    end

    // Head result with valid flag, zero otherwise
    always_comb begin
        rd_word = '0;
        if (access && read_res && !res_empty) begin
            rd_word[$bits(alu_res_t)-1:0] = res_data;
            rd_word[RD_VALID_BIT]         = 1'b1;
        end
    end

    assign apb_rsp = '{
        prdata:  rd_word,
        pready:  pready_q,
        pslverr: pslverr_q
    };

    // Error response only on a completing transfer
    a_err_needs_ready: assert property (
        @(posedge clk) disable iff (reset)
        apb_rsp.pslverr |-> apb_rsp.pready
    ) else $error("pslverr high without pready");

endmodule

//--- logic/alu_exec.sv
`timescale 1ns/1ps

module alu_exec import alu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  alu_cmd_t cmd_data,
    input  logic     cmd_empty,
    output logic     cmd_pop,
    output logic     res_push,
    output alu_res_t res_data,
    input  logic     res_full
);

    alu_res_t stg_data;                             // Output stage payload
    logic     stg_valid;
    alu_res_t calc;                                 // Next result and flags

    // Stage drains when result FIFO has room
    assign res_push = stg_valid & ~res_full;
    assign res_data = stg_data;
    assign cmd_pop  = ~cmd_empty & (~stg_valid | res_push);

    always_comb begin
        logic [DATA_W-1:0]   a;
        logic [DATA_W-1:0]   b;
        logic [DATA_W-1:0]   b_neg;
        logic [DATA_W:0]     sum;                   // Extra bit holds carry
        logic [2*DATA_W-1:0] prod;
        a       = cmd_data.operand1;
        b       = cmd_data.operand2;
        b_neg   = ~b + 1'b1;                        // Two's complement of b
        sum     = '0;
        prod    = a * b;
        calc    = '0;
        case (cmd_data.opcode)
            OP_ADD: begin
                sum          = {1'b0, a} + {1'b0, b};
                calc.result  = sum[DATA_W-1:0];
                calc.flags.c = sum[DATA_W];
                calc.flags.v = (a[DATA_W-1] == b[DATA_W-1]) &&
                               (sum[DATA_W-1] != a[DATA_W-1]);
            end
            OP_SUB: begin
                sum          = {1'b0, a} + {1'b0, b_neg};
                calc.result  = sum[DATA_W-1:0];
                calc.flags.c = sum[DATA_W];         // Zero for b = 0
                calc.flags.v = (a[DATA_W-1] != b[DATA_W-1]) &&
                               (sum[DATA_W-1] != a[DATA_W-1]);
            end
            OP_MUL: begin
                calc.result  = prod[DATA_W-1:0];    // Low byte kept
                calc.flags.c = (prod[2*DATA_W-1:DATA_W] != '0);
                calc.flags.v = (a[DATA_W-1] == b[DATA_W-1]) &&
                               (prod[DATA_W-1] != a[DATA_W-1]);
            end
            OP_AND:  calc.result = a & b;
            OP_OR:   calc.result = a | b;
            OP_XOR:  calc.result = a ^ b;
            OP_NOT:  calc.result = ~a;
            OP_NOR:  calc.result = ~(a | b);
            OP_NAND: calc.result = ~(a & b);
            OP_XNOR: calc.result = ~(a ^ b);
            default: calc.result = '0;              // Filtered at the port
        endcase
        calc.flags.z = (calc.result == '0);
        calc.flags.s = calc.result[DATA_W-1];
    end

    // One-entry output stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            stg_valid <= 1'b0;
        else if (cmd_pop)
            stg_valid <= 1'b1;                      // Refill or back-to-back
        else if (res_push)
            stg_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (cmd_pop)
            stg_data <= calc;
    end

    // Held entry survives a full result FIFO unchanged
    a_hold_on_full: assert property (
        @(posedge clk) disable iff (reset)
        stg_valid && res_full |=> stg_valid && $stable(stg_data)
    ) else $error("stage entry lost while result FIFO full");

endmodule

//--- logic/alu_top.sv
`timescale 1ns/1ps

module alu_top import alu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic     cmd_push;                             // Port into command FIFO
    alu_cmd_t cmd_wdata;
    logic     cmd_full;
    logic     cmd_pop;                              // Exec side of command FIFO
    alu_cmd_t cmd_rdata;
    logic     cmd_empty;
    logic     res_push;                             // Exec into result FIFO
    alu_res_t res_wdata;
    logic     res_full;
    logic     res_pop;                              // Port side of result FIFO
    alu_res_t res_rdata;
    logic     res_empty;

    apb_cmd_port port0 (
        .clk       (clk),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cmd_push  (cmd_push),
        .cmd_data  (cmd_wdata),
        .cmd_full  (cmd_full),
        .res_pop   (res_pop),
        .res_data  (res_rdata),
        .res_empty (res_empty)
    );

    sync_fifo #(.T(alu_cmd_t), .DEPTH(CMD_DEPTH)) cmd_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (cmd_push),
        .push_data (cmd_wdata),
        .full      (cmd_full),
        .pop       (cmd_pop),
        .pop_data  (cmd_rdata),
        .empty     (cmd_empty)
    );

    alu_exec exec0 (
        .clk       (clk),
        .reset     (reset),
        .cmd_data  (cmd_rdata),
        .cmd_empty (cmd_empty),
        .cmd_pop   (cmd_pop),
        .res_push  (res_push),
        .res_data  (res_wdata),
        .res_full  (res_full)
    );

    sync_fifo #(.T(alu_res_t), .DEPTH(RES_DEPTH)) res_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (res_push),
        .push_data (res_wdata),
        .full      (res_full),
        .pop       (res_pop),
        .pop_data  (res_rdata),
        .empty     (res_empty)
    );

endmodule

//--- tb/alu_tb.sv
`timescale 1ns/1ps

module alu_tb import alu_pkg::*; ();

    localparam int NUM_CMDS   = 106;                // Commands over all tests
    localparam int NUM_XFERS  = 2 * NUM_CMDS + 10;  // Writes, reads, error cases
    localparam int MAX_CYCLES = 30 * NUM_XFERS + 100;

    logic        clk;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] rng_state;
    logic [11:0] exp_q [$];                         // Model results in command order
    logic [11:0] exp_head;
    int          exp_count;
    logic        exp_err;                           // Error due on this transfer
    logic        stall_check;                       // Write must be held off
    int          err_count;
    int          errs_at_start;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;
    logic        xfer_done;
    logic        rd_done;

    assign xfer_done = apb_req.psel & apb_req.penable & apb_rsp.pready;
    assign rd_done   = xfer_done & ~apb_req.pwrite & (apb_req.paddr == ADDR_RES);

    alu_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #2 clk = ~clk;                           // 4 ns period

    function automatic void log_fail(input string msg);
        err_count++;
        $display("FAIL %0t: %s", $time, msg);
    endfunction

    function automatic logic [7:0] rand_byte();
        rng_state = rng_state ^ (rng_state << 13);  // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state[15:8];
    endfunction

    function automatic logic is_kept_op(input logic [7:0] op);
        return op inside {OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR,
                          OP_NOT, OP_NOR, OP_NAND, OP_XNOR};
    endfunction

    // Returns {v, c, s, z, result}
    function automatic logic [11:0] alu_model(input logic [7:0] op, input logic [7:0] a,
                                              input logic [7:0] b);
        int         full;
        int         sfull;
        logic [7:0] r;
        logic       c;
        logic       v;
        c = 1'b0;
        v = 1'b0;
        case (op)
            OP_ADD: begin
                full  = int'(a) + int'(b);
                sfull = int'($signed(a)) + int'($signed(b));
                r     = full[7:0];
                c     = (full > 255);
                v     = (sfull > 127) || (sfull < -128);  // Signed range exceeded
            end
            OP_SUB: begin
                full  = int'(a) - int'(b);
                sfull = int'($signed(a)) - int'($signed(b));
                r     = full[7:0];
                c     = (b != 8'h00) && (a >= b);  // Carry of a + (256 - b)
                v     = (sfull > 127) || (sfull < -128);
            end
            OP_MUL: begin
                full = int'(a) * int'(b);
                r    = full[7:0];
                c    = (full > 255);                // High byte non-zero
                v    = (a[7] == b[7]) && (r[7] != a[7]);
            end
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_NOT:  r = ~a;
            OP_NOR:  r = ~(a | b);
            OP_NAND: r = ~(a & b);
            OP_XNOR: r = ~(a ^ b);
            default: r = 8'h00;
        endcase
        return {v, c, r[7], (r == 8'h00), r};
    endfunction

    function automatic void push_expected(input logic [11:0] val);
        exp_q.push_back(val);
        exp_head  = exp_q[0];
        exp_count = exp_q.size();
    endfunction

    function automatic void pop_expected();
        void'(exp_q.pop_front());
        exp_head  = (exp_q.size() > 0) ? exp_q[0] : 12'h000;
        exp_count = exp_q.size();
    endfunction

    // Setup, access, then wait for pready
    task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] wdata, input logic err_exp,
                            output logic [31:0] rdata);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        exp_err         <= err_exp;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        while (!apb_rsp.pready)                     // Pre-edge value of access phase
            @(posedge clk);
        rdata = apb_rsp.prdata;
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic send_cmd(input logic [ADDR_W-1:0] addr, input logic [7:0] op,
                            input logic [7:0] a, input logic [7:0] b);
        logic        bad;
        logic [31:0] rdata;
        bad = (addr != ADDR_CMD) || !is_kept_op(op);
        apb_xfer(1'b1, addr, {8'h00, op, b, a}, bad, rdata);
        if (!bad)
            push_expected(alu_model(op, a, b));
    endtask

    task automatic read_result();
        logic [31:0] word;
        apb_xfer(1'b0, ADDR_RES, 32'h0, 1'b0, word);
        if (word[RD_VALID_BIT] && exp_count > 0)
            pop_expected();
    endtask

    task automatic drain();
        while (exp_count > 0)                       // Poll until every result is back
            read_result();
    endtask

    // Batches of 8 stay below the 9-entry capacity
    task automatic send_batched(input logic [7:0] op, input logic [7:0] a, input logic [7:0] b);
        send_cmd(ADDR_CMD, op, a, b);
        if (exp_count >= 8)
            drain();
    endtask

    // Write to a full pipeline, then withdrawn
    task automatic stalled_write(input logic [7:0] a, input logic [7:0] b, input int hold);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b1;
        apb_req.paddr   <= ADDR_CMD;
        apb_req.pwdata  <= {8'h00, OP_ADD, b, a};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        stall_check     <= 1'b1;
        repeat (hold) @(posedge clk);
        apb_req.psel    <= 1'b0;                    // Single master must read first
        apb_req.penable <= 1'b0;
        stall_check     <= 1'b0;
    endtask

    task automatic end_test(input string name);
        @(negedge clk);                             // Let assertions of last edge settle
        tests_run++;
        if (err_count != errs_at_start) begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", name, err_count - errs_at_start);
        end else begin
            $display("test %s: passed", name);
        end
        errs_at_start = err_count;
    endtask

    a_reset_idle: assert property (@(posedge clk)
        $fell(reset) |-> !apb_rsp.pready && !apb_rsp.pslverr
    ) else log_fail("pready or pslverr high right after reset");

    a_err_resp: assert property (@(posedge clk)
        xfer_done |-> apb_rsp.pslverr == exp_err
    ) else log_fail($sformatf("pslverr %0b, expected %0b",
                              $sampled(apb_rsp.pslverr), $sampled(exp_err)));

    a_read_match: assert property (@(posedge clk)
        rd_done && apb_rsp.prdata[RD_VALID_BIT] |->
            exp_count > 0 && apb_rsp.prdata == {15'h0, 1'b1, 4'h0, exp_head}
    ) else log_fail($sformatf("read 0x%08h, expected head 0x%03h of %0d queued",
                              $sampled(apb_rsp.prdata), $sampled(exp_head),
                              $sampled(exp_count)));

    a_read_empty: assert property (@(posedge clk)
        rd_done && (exp_count == 0 || !apb_rsp.prdata[RD_VALID_BIT]) |->
            apb_rsp.prdata == 32'h0
    ) else log_fail($sformatf("read 0x%08h with no result due",
                              $sampled(apb_rsp.prdata)));

    a_stall_hold: assert property (@(posedge clk)
        stall_check |-> !apb_rsp.pready
    ) else log_fail("write to a full pipeline got pready");

    initial begin
        logic [7:0] edge_val [4];
        logic [7:0] logic_ops [7];
        logic [7:0] a;
        logic [7:0] b;
        clk           = 1'b0;
        reset         = 1'b1;
        apb_req       = '0;
        rng_state     = 32'd91067;
        exp_head      = 12'h000;
        exp_count     = 0;
        exp_err       = 1'b0;
        stall_check   = 1'b0;
        err_count     = 0;
        errs_at_start = 0;
        tests_run     = 0;
        tests_failed  = 0;
        edge_val      = '{8'h00, 8'h7F, 8'h80, 8'hFF};
        logic_ops     = '{OP_AND, OP_OR, OP_XOR, OP_NOT, OP_NOR, OP_NAND, OP_XNOR};
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        repeat (2) @(posedge clk);
        read_result();                              // Nothing queued yet
        end_test("reset_idle");

        for (int i = 0; i < 32; i++)                // All edge pairs, ADD then SUB
            send_batched((i < 16) ? OP_ADD : OP_SUB, edge_val[i % 4], edge_val[(i / 4) % 4]);
        for (int i = 0; i < 16; i++) begin
            a = rand_byte();
            b = rand_byte();
            send_batched(i[0] ? OP_SUB : OP_ADD, a, b);
        end
        drain();
        end_test("add_sub");

        send_batched(OP_MUL, 8'hFF, 8'hFF);
        send_batched(OP_MUL, 8'h80, 8'h02);         // Low byte zero, carry set
        send_batched(OP_MUL, 8'h00, 8'h5A);
        send_batched(OP_MUL, 8'h7F, 8'h01);
        for (int i = 0; i < 16; i++) begin
            a = rand_byte();
            b = rand_byte();
            send_batched(OP_MUL, a, b);
        end
        drain();
        end_test("mul");

        foreach (logic_ops[k]) begin
            a = rand_byte();
            b = rand_byte();
            send_batched(logic_ops[k], a, b);
            send_batched(logic_ops[k], 8'h00, 8'h00);
            send_batched(logic_ops[k], 8'hFF, 8'hFF);
            send_batched(logic_ops[k], 8'hF0, 8'h0F);
        end
        drain();
        end_test("logic_ops");

        send_cmd(ADDR_CMD, 8'd0, 8'h11, 8'h22);
        send_cmd(ADDR_CMD, 8'd4, 8'h11, 8'h22);
        send_cmd(ADDR_CMD, 8'd5, 8'h11, 8'h22);
        send_cmd(ADDR_CMD, 8'd13, 8'h11, 8'h22);
        send_cmd(ADDR_RES, OP_ADD, 8'h12, 8'h34);   // Legal opcode, read-only address
        repeat (8) @(posedge clk);
        read_result();
        end_test("bad_writes");

        for (int i = 0; i < 9; i++) begin           // Fill FIFOs and stage
            a = rand_byte();
            b = rand_byte();
            send_cmd(ADDR_CMD, OP_ADD, a, b);
        end
        a = rand_byte();
        b = rand_byte();
        stalled_write(a, b, 12);
        read_result();                              // Frees one slot
        send_cmd(ADDR_CMD, OP_ADD, a, b);
        drain();
        end_test("back_pressure");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- src.f
logic/alu_pkg.sv
logic/sync_fifo.sv
logic/apb_cmd_port.sv
logic/alu_exec.sv
logic/alu_top.sv
tb/alu_tb.sv
